// File: src/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus masters, index 3 wins arbitration.
`define NR_OF_MASTERS 4

// cycles between the pll lock and the reset release.
`define RESET_RELEASE_CYCLES 16

`define BUS_TIMEOUT_CYCLES 64

// gpio lives at 0x4xxxxxxx, offsets are byte offsets inside the region.
`define GPIO_REGION 2'b01
`define GPIO_SWITCH_OFFSET 30'h0
`define GPIO_SEGMENT_OFFSET 30'h4

`define CI_SWAP_BYTE 8'd1
`define CI_GRAYSCALE 8'd9

`endif

// File: src/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // the same bus word is an address in the begin cycle and data afterwards.
  typedef union packed {
    struct packed {
      logic [1:0]  region;
      logic [27:0] offset;
      logic [1:0]  unused;
    } address;
    logic [3:0][7:0] bytes;
  } busWord_t;

  typedef struct packed {
    logic       beginTransaction;
    logic       endTransaction;
    logic       readNotWrite;
    logic       dataValid;
    logic       busError;
    logic [3:0] byteEnables;
    logic [7:0] burstSize;
    busWord_t   addressData;
  } busSignals_t;

  typedef struct packed {
    logic        start;
    logic [7:0]  ciN;
    logic [31:0] dataA;
    logic [31:0] dataB;
  } ciRequest_t;

  typedef struct packed {
    logic        done;
    logic [31:0] result;
  } ciResponse_t;

endpackage

`default_nettype wire

// File: src/resetSequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset,
  output logic peripheralResetN
);

  logic [4:0] s_resetCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCount <= 5'd0;
    end else if (s_resetCount != 5'(`RESET_RELEASE_CYCLES)) begin
      s_resetCount <= s_resetCount + 5'd1; // stops once the top bit is set.
    end
  end

  assign peripheralResetN = s_resetCount[4];
  assign systemReset      = ~s_resetCount[4];

endmodule

`default_nettype wire

// File: src/busArbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module busArbiter import soc_pkg::*; (
  input  logic                      s_systemClock,
  input  logic                      systemReset,
  input  logic [`NR_OF_MASTERS-1:0] busRequests,
  output logic [`NR_OF_MASTERS-1:0] busGrants,
  input  busSignals_t               sharedBus,
  output busSignals_t               arbiterBus
);

  logic [`NR_OF_MASTERS-1:0] s_nextGrant;
  logic                      s_transactionActive;
  logic [6:0]                s_watchdog;
  logic                      s_timeout;

  // highest set request bit wins.
  always_comb begin
    s_nextGrant = '0;
    for (int i = 0; i < `NR_OF_MASTERS; i++) begin
      if (busRequests[i]) begin
        s_nextGrant    = '0;
        s_nextGrant[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      busGrants <= '0;
    end else if (sharedBus.endTransaction) begin
      busGrants <= '0;
    end else if (busGrants == '0) begin
      busGrants <= s_nextGrant;
    end
  end

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      s_transactionActive <= 1'b0;
    end else if (sharedBus.beginTransaction) begin
      s_transactionActive <= 1'b1;
    end else if (sharedBus.endTransaction) begin
      s_transactionActive <= 1'b0;
    end
  end

  // the watchdog holds the number of cycles since the last sign of life.
  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      s_watchdog <= 7'd0;
    end else if (sharedBus.beginTransaction || sharedBus.dataValid) begin
      s_watchdog <= 7'd1;
    end else if (s_transactionActive && !s_timeout) begin
      s_watchdog <= s_watchdog + 7'd1;
    end
  end

  assign s_timeout = s_transactionActive && (s_watchdog == 7'(`BUS_TIMEOUT_CYCLES));

  always_comb begin
    arbiterBus                = '0;
    arbiterBus.busError       = s_timeout;
    arbiterBus.endTransaction = s_timeout; // our own end clears the active flag.
  end

endmodule

`default_nettype wire

// File: src/gpioSlave.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module gpioSlave import soc_pkg::*; (
  input  logic        s_systemClock,
  input  logic        systemReset,
  input  busSignals_t sharedBus,
  input  logic [7:0]  dipSwitch,
  output logic [23:0] sevenSegments,
  output busSignals_t gpioBus
);

  logic [7:0]  s_dipSync1;
  logic [7:0]  s_dipSync2;
  logic        s_hit;
  logic        s_isBurst;
  logic [29:0] s_byteOffset;
  logic [31:0] s_readValue;
  logic [31:0] s_readData;
  logic        s_readDataValid;
  logic        s_readEnd;
  logic        s_burstError;
  logic        s_writeActive;
  logic [2:0]  s_writeEnables;

  always_ff @(posedge s_systemClock) begin
    s_dipSync1 <= dipSwitch;
    s_dipSync2 <= s_dipSync1;
  end

  assign s_hit        = sharedBus.beginTransaction &&
                        (sharedBus.addressData.address.region == `GPIO_REGION);
  assign s_isBurst    = sharedBus.burstSize != 8'd0;
  assign s_byteOffset = {sharedBus.addressData.address.offset, 2'b00};

  always_comb begin
    s_readValue = 32'd0;
    if (s_byteOffset == `GPIO_SWITCH_OFFSET) s_readValue = {24'd0, s_dipSync2};
    if (s_byteOffset == `GPIO_SEGMENT_OFFSET) s_readValue = {8'd0, sevenSegments};
  end

  always_ff @(posedge s_systemClock) begin
    if (s_hit) begin
      s_readData     <= s_readValue;
      s_writeEnables <= sharedBus.byteEnables[2:0];
    end
  end

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      s_readDataValid <= 1'b0;
      s_readEnd       <= 1'b0;
      s_burstError    <= 1'b0;
      s_writeActive   <= 1'b0;
    end else begin
      s_readDataValid <= s_hit && !s_isBurst && sharedBus.readNotWrite;
      s_readEnd       <= s_readDataValid;
      s_burstError    <= s_hit && s_isBurst;
      if (s_hit && !s_isBurst && !sharedBus.readNotWrite) begin
        s_writeActive <= s_byteOffset == `GPIO_SEGMENT_OFFSET; // other offsets drop writes.
      end else if (sharedBus.endTransaction) begin
        s_writeActive <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      sevenSegments <= 24'd0;
    end else if (s_writeActive && sharedBus.dataValid) begin
      for (int i = 0; i < 3; i++) begin
        if (s_writeEnables[i]) sevenSegments[8*i +: 8] <= sharedBus.addressData.bytes[i];
      end
    end
  end

  always_comb begin
    gpioBus                = '0;
    gpioBus.dataValid      = s_readDataValid;
    gpioBus.addressData    = s_readDataValid ? s_readData : 32'd0;
    gpioBus.endTransaction = s_readEnd | s_burstError;
    gpioBus.busError       = s_burstError;
  end

endmodule

`default_nettype wire

// File: src/swapByteIse.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module swapByteIse import soc_pkg::*; (
  input  ciRequest_t  ciRequest,
  output ciResponse_t ciResponse
);

  logic [31:0] s_dataA;
  logic [31:0] s_fullSwap;
  logic [31:0] s_halfSwap;

  assign s_dataA    = ciRequest.dataA;
  assign s_fullSwap = {s_dataA[7:0], s_dataA[15:8], s_dataA[23:16], s_dataA[31:24]};
  assign s_halfSwap = {s_dataA[23:16], s_dataA[31:24], s_dataA[7:0], s_dataA[15:8]};

  always_comb begin
    ciResponse = '0;
    if (ciRequest.start && (ciRequest.ciN == `CI_SWAP_BYTE)) begin
      ciResponse.done   = 1'b1;
      ciResponse.result = ciRequest.dataB[0] ? s_halfSwap : s_fullSwap; // bit 0 picks the mode.
    end
  end

endmodule

`default_nettype wire

// File: src/rgb565GrayscaleIse.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module rgb565GrayscaleIse import soc_pkg::*; (
  input  ciRequest_t  ciRequest,
  output ciResponse_t ciResponse
);

  logic [7:0]  s_red;
  logic [7:0]  s_green;
  logic [7:0]  s_blue;
  logic [15:0] s_weighted;

  assign s_red   = {ciRequest.dataA[15:11], 3'b000};
  assign s_green = {ciRequest.dataA[10:5], 2'b00};
  assign s_blue  = {ciRequest.dataA[4:0], 3'b000};

  // weights sum to 256, so the top byte is the gray level.
  assign s_weighted = 16'd54 * 16'(s_red) + 16'd183 * 16'(s_green) + 16'd19 * 16'(s_blue);

  always_comb begin
    ciResponse = '0;
    if (ciRequest.start && (ciRequest.ciN == `CI_GRAYSCALE)) begin
      ciResponse.done   = 1'b1;
      ciResponse.result = {24'd0, s_weighted[15:8]};
    end
  end

endmodule

`default_nettype wire

// File: src/singleCoreSoc.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module singleCoreSoc import soc_pkg::*; (
  input  logic                      s_systemClock,
  input  logic                      s_pllLocked,
  input  logic [`NR_OF_MASTERS-1:0] busRequests,
  output logic [`NR_OF_MASTERS-1:0] busGrants,
  input  busSignals_t               masterBus,
  output busSignals_t               sharedBus,
  input  ciRequest_t                ciRequest,
  output ciResponse_t               ciResponse,
  input  logic [7:0]                dipSwitch,
  output logic [23:0]               sevenSegments,
  output logic                      peripheralResetN
);

  logic        s_systemReset;
  busSignals_t s_arbiterBus;
  busSignals_t s_gpioBus;
  ciResponse_t s_swapByteResponse;
  ciResponse_t s_grayscaleResponse;

  resetSequencer resetCounter (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .systemReset     (s_systemReset),
    .peripheralResetN(peripheralResetN)
  );

  busArbiter arbiter (
    .s_systemClock(s_systemClock),
    .systemReset  (s_systemReset),
    .busRequests  (busRequests),
    .busGrants    (busGrants),
    .sharedBus    (sharedBus),
    .arbiterBus   (s_arbiterBus)
  );

  gpioSlave sevenSegDipSwitch (
    .s_systemClock(s_systemClock),
    .systemReset  (s_systemReset),
    .sharedBus    (sharedBus),
    .dipSwitch    (dipSwitch),
    .sevenSegments(sevenSegments),
    .gpioBus      (s_gpioBus)
  );

  swapByteIse ise1 (
    .ciRequest (ciRequest),
    .ciResponse(s_swapByteResponse)
  );

  rgb565GrayscaleIse converter (
    .ciRequest (ciRequest),
    .ciResponse(s_grayscaleResponse)
  );

  // idle agents drive zeros, so a plain or merges them.
  assign sharedBus  = masterBus | s_arbiterBus | s_gpioBus;
  assign ciResponse = s_swapByteResponse | s_grayscaleResponse;

endmodule

`default_nettype wire

// File: test/singleCoreSoc_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module singleCoreSoc_checker import soc_pkg::*; (
  input logic                      s_systemClock,
  input logic [`NR_OF_MASTERS-1:0] busGrants,
  input busSignals_t               sharedBus,
  input logic                      peripheralResetN
);

  // only one master may own the bus at a time.
  grantOneHot: assert property (@(posedge s_systemClock) $onehot0(busGrants))
    else $error("busGrants %b is not one-hot", busGrants);

  errorWithEnd: assert property (@(posedge s_systemClock)
    sharedBus.busError |-> sharedBus.endTransaction)
    else $error("busError seen without endTransaction");

  noGrantInReset: assert property (@(posedge s_systemClock)
    !peripheralResetN |-> (busGrants == '0))
    else $error("grant %b given while the peripherals are in reset", busGrants);

endmodule

`default_nettype wire

// File: test/singleCoreSoc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_params.svh"

module singleCoreSoc_tb import soc_pkg::*; ();

  localparam int TEST_CYCLES = 4 + 17 + 3 * 12 + 6 * 24 + 70 + 6 + 16 * 4;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * 100;

  logic                      s_systemClock = 1'b0;
  logic                      s_pllLocked;
  logic [`NR_OF_MASTERS-1:0] busRequests;
  logic [`NR_OF_MASTERS-1:0] busGrants;
  busSignals_t               masterBus;
  busSignals_t               sharedBus;
  ciRequest_t                ciRequest;
  ciResponse_t               ciResponse;
  logic [7:0]                dipSwitch;
  logic [23:0]               sevenSegments;
  logic                      peripheralResetN;
  logic [31:0]               lfsrState = 32'h14d170dd;
  string                     nameQueue[$];
  logic [31:0]               expectedQueue[$];
  logic [31:0]               actualQueue[$];
  string                     checkName;
  logic [31:0]               expectedValue;
  logic [31:0]               actualValue;
  logic [23:0]               segmentModel;
  logic [31:0]               dataA;
  logic [31:0]               dataB;
  logic [3:0]                enables;

  always #50 s_systemClock = ~s_systemClock;

  singleCoreSoc i_singleCoreSoc (.*);

  bind singleCoreSoc singleCoreSoc_checker busChecks (
    .s_systemClock   (s_systemClock),
    .busGrants       (busGrants),
    .sharedBus       (sharedBus),
    .peripheralResetN(peripheralResetN)
  );

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  function logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = 32'd0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic logic [31:0] swapReference(input logic [31:0] a, input logic halfWords);
    logic [31:0] result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = halfWords ? a[8*(i ^ 1) +: 8] : a[8*(3 - i) +: 8];
    end
    return result;
  endfunction

  function automatic logic [31:0] grayReference(input logic [31:0] a);
    int red;
    int green;
    int blue;
    red   = int'(a[15:11]) * 8;
    green = int'(a[10:5]) * 4;
    blue  = int'(a[4:0]) * 8;
    return 32'((54 * red + 183 * green + 19 * blue) / 256);
  endfunction

  function automatic logic [23:0] segmentMerge(input logic [23:0] old, input logic [3:0] en,
                                               input logic [31:0] data);
    logic [23:0] result;
    result = old;
    for (int i = 0; i < 3; i++) begin
      if (en[i]) result[8*i +: 8] = data[8*i +: 8];
    end
    return result;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    nameQueue.push_back(name);
    expectedQueue.push_back(expected);
    actualQueue.push_back(actual);
  endtask

  always @(negedge s_systemClock) begin
    while (expectedQueue.size() > 0) begin
      checkName     = nameQueue.pop_front();
      expectedValue = expectedQueue.pop_front();
      actualValue   = actualQueue.pop_front();
      assert (actualValue === expectedValue) else begin
        $display("[FAIL] %s expected %h actual %h", checkName, expectedValue, actualValue);
        $display("sim failed");
        $fatal(1, "value mismatch");
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("the run did not finish within the expected time");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  task automatic acquireBus(input int index);
    @(posedge s_systemClock);
    busRequests[index] <= 1'b1;
    do @(negedge s_systemClock); while (busGrants == '0);
    checkValue("grant", 32'(4'b0001 << index), 32'(busGrants));
  endtask

  // drives the begin cycle and drops the request, the grant holds until the end.
  task automatic beginTransaction(input int index, input logic [31:0] address,
                                  input logic read, input logic [7:0] burst,
                                  input logic [3:0] en);
    busSignals_t word;
    word = '0;
    word.beginTransaction = 1'b1;
    word.readNotWrite     = read;
    word.byteEnables      = en;
    word.burstSize        = burst;
    word.addressData      = address;
    @(posedge s_systemClock);
    masterBus          <= word;
    busRequests[index] <= 1'b0;
  endtask

  task automatic readGpio(input int index, input logic [31:0] address,
                          input logic [31:0] expected);
    acquireBus(index);
    beginTransaction(index, address, 1'b1, 8'd0, 4'hf);
    @(posedge s_systemClock);
    masterBus <= '0;
    @(negedge s_systemClock);
    checkValue("read valid", 32'd1, 32'(sharedBus.dataValid));
    checkValue("read data", expected, sharedBus.addressData);
    checkValue("grant hold", 32'(4'b0001 << index), 32'(busGrants));
    @(negedge s_systemClock);
    checkValue("read end", 32'd1, 32'({sharedBus.busError, sharedBus.endTransaction}));
    checkValue("grant hold", 32'(4'b0001 << index), 32'(busGrants));
  endtask

  task automatic writeSegments(input logic [3:0] en, input logic [31:0] data);
    busSignals_t word;
    word = '0;
    word.dataValid      = 1'b1;
    word.endTransaction = 1'b1;
    word.byteEnables    = en;
    word.addressData    = data;
    acquireBus(0);
    beginTransaction(0, 32'h40000004, 1'b0, 8'd0, en);
    @(posedge s_systemClock);
    masterBus <= word;
    @(posedge s_systemClock);
    masterBus <= '0;
  endtask

  task automatic issueInstruction(input logic [7:0] ciN, input logic [31:0] a,
                                  input logic [31:0] b, input logic done,
                                  input logic [31:0] expected);
    @(posedge s_systemClock);
    ciRequest <= {1'b1, ciN, a, b};
    @(negedge s_systemClock);
    checkValue("ci done", 32'(done), 32'(ciResponse.done));
    checkValue("ci result", expected, ciResponse.result);
    @(posedge s_systemClock);
    ciRequest <= '0;
  endtask

  initial begin
    s_pllLocked  = 1'b0;
    busRequests  = '0;
    masterBus    = '0;
    ciRequest    = '0;
    dipSwitch    = 8'(randomBits(8));
    segmentModel = 24'd0;
    repeat (4) begin
      @(negedge s_systemClock);
      checkValue("reset outputs", 32'd0,
                 32'({peripheralResetN, 4'(busGrants), sevenSegments}));
    end
    @(posedge s_systemClock);
    s_pllLocked    <= 1'b1;
    busRequests[0] <= 1'b1; // early request must wait for the release.
    for (int edgeCount = 0; edgeCount <= `RESET_RELEASE_CYCLES; edgeCount++) begin
      @(negedge s_systemClock);
      checkValue("reset release", 32'(edgeCount == `RESET_RELEASE_CYCLES),
                 32'(peripheralResetN));
      checkValue("grant in reset", 32'd0, 32'(busGrants));
    end
    for (int i = 0; i < 6; i++) begin
      enables = 4'(randomBits(4));
      dataA   = randomBits(32);
      writeSegments(enables, dataA);
      segmentModel = segmentMerge(segmentModel, enables, dataA);
      @(negedge s_systemClock);
      checkValue("segments", 32'(segmentModel), 32'(sevenSegments));
      readGpio(0, 32'h40000004, {8'd0, segmentModel});
    end
    @(posedge s_systemClock);
    busRequests <= 4'b1011;
    readGpio(3, 32'h40000000, {24'd0, dipSwitch});
    readGpio(1, 32'h40000004, {8'd0, segmentModel});
    readGpio(0, 32'h40000000, {24'd0, dipSwitch});
    acquireBus(2);
    beginTransaction(2, 32'h80000000, 1'b1, 8'd0, 4'hf);
    @(posedge s_systemClock);
    masterBus <= '0;
    for (int cycle = 1; cycle <= `BUS_TIMEOUT_CYCLES; cycle++) begin
      @(negedge s_systemClock);
      checkValue("timeout", (cycle == `BUS_TIMEOUT_CYCLES) ? 32'd3 : 32'd0,
                 32'({sharedBus.busError, sharedBus.endTransaction}));
    end
    acquireBus(1);
    beginTransaction(1, 32'h40000000, 1'b1, 8'd4, 4'hf);
    @(posedge s_systemClock);
    masterBus <= '0;
    @(negedge s_systemClock);
    checkValue("burst error", 32'd3, 32'({sharedBus.busError, sharedBus.endTransaction}));
    for (int i = 0; i < 8; i++) begin
      dataA = randomBits(32);
      dataB = {31'(randomBits(31)), 1'(i)};
      issueInstruction(`CI_SWAP_BYTE, dataA, dataB, 1'b1, swapReference(dataA, dataB[0]));
      issueInstruction(`CI_GRAYSCALE, dataA, dataB, 1'b1, grayReference(dataA));
    end
    issueInstruction(8'd5, dataA, dataB, 1'b0, 32'd0);
    repeat (2) @(negedge s_systemClock);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/soc_pkg.sv
src/resetSequencer.sv
src/busArbiter.sv
src/gpioSlave.sv
src/swapByteIse.sv
src/rgb565GrayscaleIse.sv
src/singleCoreSoc.sv
test/singleCoreSoc_checker.sv
test/singleCoreSoc_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module singleCoreSoc_tb -o simv &&
./obj_dir/simv || exit 1
